//--- common/plotter_pkg.sv
package plotter_pkg;

  // ************************************************************
  // widths and basic types
  // ************************************************************
  localparam int coord_w = 12;                      // screen coordinate width

  typedef logic signed [coord_w-1:0] coord_t;       // signed so the clip test sees negatives
  typedef logic [3:0]                aux_t;         // pixel writer function code

  // pixel writer function codes
  localparam aux_t aux_pxwri         = 4'd1;        // write pixel
  localparam aux_t aux_rst_pxwri_m   = 4'd10;       // reset write collision counter
  localparam aux_t aux_rst_pxpaste_m = 4'd11;       // reset paste collision counter
  localparam aux_t aux_dstrwdth      = 4'd12;       // destination raster width
  localparam aux_t aux_srcrwdth      = 4'd13;       // source raster width
  localparam aux_t aux_dstmaddr      = 4'd14;       // destination base address
  localparam aux_t aux_srcmaddr      = 4'd15;       // source base address

  // ************************************************************
  // command word opcodes
  // ************************************************************
  localparam logic [1:0] kind_x = 2'b10;            // load x[idx]
  localparam logic [1:0] kind_y = 2'b11;            // load y[idx]

  localparam logic [7:0] op_idx4_mask = 8'hFC;      // groups of four with the low 2 bits free
  localparam logic [7:0] op_pair_mask = 8'hFE;      // groups of two
  localparam logic [7:0] op_draw_mask = 8'hE0;      // draw range 00..1F

  localparam logic [7:0] op_dstmaddr  = 8'h7C;      // 7C..7F
  localparam logic [7:0] op_srcmaddr  = 8'h78;      // 78..7B
  localparam logic [7:0] op_rwdth     = 8'h70;      // 70..73 where bit0 picks dst or src
  localparam logic [7:0] op_clip      = 8'h5C;      // 5C..5F
  localparam logic [7:0] op_rst_m     = 8'h5A;      // 5A paste, 5B write
  localparam logic [7:0] op_draw      = 8'h00;      // shape in bits 2:0, fill in bit 3

  localparam logic [2:0] shape_rect   = 3'd2;       // only shape with an engine

  // coordinate load view with kind, index and 12-bit value
  typedef struct packed {
    logic [1:0]         kind;
    logic [1:0]         idx;
    logic [coord_w-1:0] value;
  } coord_load_t;

  // operation view with opcode byte and data byte
  typedef struct packed {
    logic [7:0] opcode;
    logic [7:0] data;
  } op_word_t;

  typedef union packed {
    coord_load_t load;
    op_word_t    op;
  } cmd_word_t;

  // ************************************************************
  // draw side
  // ************************************************************
  typedef struct packed {
    aux_t       aux;                                // 35:32
    logic [7:0] color;                              // 31:24 color or mode byte
    coord_t     y;                                  // 23:12
    coord_t     x;                                  // 11:0
  } draw_cmd_t;

  typedef struct packed {
    coord_t     x0;                                 // start corner
    coord_t     y0;
    coord_t     x1;                                 // end corner
    coord_t     y1;
    logic       fill;                               // 0 = outline only
    logic [7:0] color;
    coord_t     max_x;                              // clip window from the origin
    coord_t     max_y;
  } rect_job_t;

endpackage

//--- src/cmd_fifo.sv
`timescale 1ns/1ps

module cmd_fifo #(
  parameter int FIFO_DEPTH  = 512,
  parameter int FIFO_MARGIN = 32
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   wr,
  input  plotter_pkg::cmd_word_t din,
  input  logic                   pop,
  output plotter_pkg::cmd_word_t q,
  output logic                   empty,
  output logic                   almost_full
);
  import plotter_pkg::*;

  localparam int AW = $clog2(FIFO_DEPTH);           // pointer width
  localparam int CW = $clog2(FIFO_DEPTH + 1);       // count reaches FIFO_DEPTH

  cmd_word_t     mem [FIFO_DEPTH];                  // command storage
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic [CW-1:0] count_next;
  logic          do_wr;
  logic          do_rd;

  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
    return (p == AW'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;   // wrap for any depth
  endfunction

  assign do_wr = wr && (count != CW'(FIFO_DEPTH));  // drop writes when full
  assign do_rd = pop && !empty;                     // drop pops when empty
  assign empty = (count == '0);
  assign q     = mem[rd_ptr];                       // show-ahead head word

  assign count_next = count + CW'(do_wr) - CW'(do_rd);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      almost_full <= 1'b0;
    end else begin
      if (do_wr) wr_ptr <= ptr_inc(wr_ptr);
      if (do_rd) rd_ptr <= ptr_inc(rd_ptr);
      count       <= count_next;
      almost_full <= (count_next >= CW'(FIFO_DEPTH - FIFO_MARGIN)); // spare slots left
    end
  end

  // write port
  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= din;
  end

endmodule

//--- geometry/cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder (
  input  logic                   clk,
  input  logic                   reset,
  input  plotter_pkg::cmd_word_t head,
  input  logic                   empty,
  input  logic                   out_ready,
  input  logic                   rect_busy,
  output logic                   pop,
  output logic                   load_cmd,
  output plotter_pkg::draw_cmd_t reg_cmd,
  output logic                   reg_valid,
  output plotter_pkg::rect_job_t rect_job,
  output logic                   start
);
  import plotter_pkg::*;

  coord_t     x [4];                                // corner registers x0..x3
  coord_t     y [4];                                // corner registers y0..y3
  coord_t     max_x;                                // clip window
  coord_t     max_y;

  logic [7:0] op;                                   // opcode byte of head word
  logic [7:0] d;                                    // data byte of head word
  logic [1:0] sel;                                  // corner used by a register command
  logic [1:0] clip_sel;                             // 5F -> 0 ... 5C -> 3
  logic       is_load;
  logic       is_clip;
  logic       is_rect;
  logic       has_out;                              // word produces a draw command
  logic       can_take;

  assign op       = head.op.opcode;
  assign d        = head.op.data;
  assign clip_sel = ~op[1:0];
  assign sel      = ((op & op_idx4_mask) == op_rwdth) ? {1'b1, ~op[1]} : op[1:0];

  // ************************************************************
  // opcode decode
  // ************************************************************
  always_comb begin
    is_load       = 1'b0;
    is_clip       = 1'b0;
    is_rect       = 1'b0;
    has_out       = 1'b1;
    reg_cmd.aux   = '0;
    reg_cmd.color = d;                              // mode byte comes straight from data
    reg_cmd.y     = y[sel];
    reg_cmd.x     = x[sel];
    if (head.load.kind == kind_x || head.load.kind == kind_y) begin
      is_load = 1'b1;
      has_out = 1'b0;
    end else if ((op & op_idx4_mask) == op_dstmaddr) begin
      reg_cmd.aux = aux_dstmaddr;
    end else if ((op & op_idx4_mask) == op_srcmaddr) begin
      reg_cmd.aux = aux_srcmaddr;
    end else if ((op & op_idx4_mask) == op_rwdth) begin
      reg_cmd.aux = op[0] ? aux_dstrwdth : aux_srcrwdth;   // 73/71 dst, 72/70 src
    end else if ((op & op_idx4_mask) == op_clip) begin
      is_clip = 1'b1;
      has_out = 1'b0;
    end else if ((op & op_pair_mask) == op_rst_m) begin
      reg_cmd.aux = op[0] ? aux_rst_pxwri_m : aux_rst_pxpaste_m;
      reg_cmd.y   = {d, d[7:4]};                    // mask color spread over y
      reg_cmd.x   = {4'h0, d[3:0], d[7:4]};
    end else begin
      has_out = 1'b0;                               // draw ops and unknown words
      is_rect = ((op & op_draw_mask) == op_draw) && (op[2:0] == shape_rect);
    end
  end

  // hold off everything while a rectangle runs so output order is kept
  assign can_take  = !empty && !rect_busy;
  assign reg_valid = can_take && has_out;
  assign pop       = can_take && (out_ready || !has_out);
  assign load_cmd  = ~rect_busy;

  // ************************************************************
  // coordinate and clip registers
  // ************************************************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 4; i++) begin
        x[i] <= '0;
        y[i] <= '0;
      end
      max_x <= '0;
      max_y <= '0;
      start <= 1'b0;
    end else begin
      start <= pop && is_rect;                      // one-cycle launch after the pop
      if (pop && is_load) begin
        if (head.load.kind == kind_x) x[head.load.idx] <= head.load.value;
        else                          y[head.load.idx] <= head.load.value;
      end
      if (pop && is_clip) begin
        max_x <= x[clip_sel];
        max_y <= y[clip_sel];
      end
    end
  end

  // job snapshot taken when a rectangle is popped
  always_ff @(posedge clk) begin
    if (pop && is_rect) begin
      rect_job.x0    <= x[0];
      rect_job.y0    <= y[0];
      rect_job.x1    <= x[1];
      rect_job.y1    <= y[1];
      rect_job.fill  <= op[3];
      rect_job.color <= d;
      rect_job.max_x <= max_x;
      rect_job.max_y <= max_y;
    end
  end

endmodule

//--- geometry/rect_engine.sv
`timescale 1ns/1ps

module rect_engine (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  plotter_pkg::rect_job_t job,
  input  logic                   out_ready,
  output plotter_pkg::draw_cmd_t pix_cmd,
  output logic                   pix_valid,
  output logic                   rect_busy
);
  import plotter_pkg::*;

  rect_job_t job_q;                                 // latched job
  coord_t    xdir;                                  // -1, 0 or +1
  coord_t    ydir;
  coord_t    cx;                                    // current candidate pixel
  coord_t    cy;
  logic      running;
  logic      visible;                               // candidate inside clip window
  logic      advance;                               // move to next candidate this edge
  logic      last_x;
  logic      last_y;
  logic      edge_row;                              // first or last row of the walk

  function automatic coord_t step_dir(input coord_t from, input coord_t to);
    if (to > from) return coord_t'(1);
    if (to < from) return coord_t'(-1);
    return '0;                                      // equal corners are never stepped
  endfunction

  // ************************************************************
  // walk control
  // ************************************************************
  assign last_x   = (cx == job_q.x1);
  assign last_y   = (cy == job_q.y1);
  assign edge_row = (cy == job_q.y0) || last_y;
  assign visible  = (cx >= 0) && (cx <= job_q.max_x) && (cy >= 0) && (cy <= job_q.max_y);
  assign advance  = running && (out_ready || !visible);   // clipped pixel costs a cycle

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      running <= 1'b0;
      cx      <= '0;
      cy      <= '0;
    end else if (start) begin
      running <= 1'b1;
      cx      <= job.x0;
      cy      <= job.y0;
    end else if (advance) begin
      if (last_x) begin                             // end of row reached
        cx <= job_q.x0;
        if (last_y) running <= 1'b0;
        else        cy      <= cy + ydir;
      end else if (!job_q.fill && !edge_row) begin
        cx <= job_q.x1;                             // outline rows jump to the far side
      end else begin
        cx <= cx + xdir;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      job_q <= job;
      xdir  <= step_dir(job.x0, job.x1);
      ydir  <= step_dir(job.y0, job.y1);
    end
  end

  // ************************************************************
  // pixel output
  // ************************************************************
  assign pix_valid     = running && visible;
  assign pix_cmd.aux   = aux_pxwri;
  assign pix_cmd.color = job_q.color;
  assign pix_cmd.y     = cy;
  assign pix_cmd.x     = cx;
  assign rect_busy     = start || running;          // covers the launch cycle too

endmodule

//--- src/draw_cmd_out.sv
`timescale 1ns/1ps

module draw_cmd_out (
  input  logic                   clk,
  input  logic                   reset,
  input  plotter_pkg::draw_cmd_t reg_cmd,
  input  plotter_pkg::draw_cmd_t pix_cmd,
  input  logic                   reg_valid,
  input  logic                   pix_valid,
  input  logic                   draw_busy,
  output logic                   out_ready,
  output plotter_pkg::draw_cmd_t draw_cmd,
  output logic                   draw_cmd_rdy
);
  import plotter_pkg::*;

  draw_cmd_t src_cmd;                               // selected producer
  logic      full;                                  // slot holds a command
  logic      take;                                  // pixel writer consumes this edge
  logic      load;

  assign take      = full && !draw_busy;
  assign out_ready = !full || take;                 // empty or emptying now
  assign load      = out_ready && (reg_valid || pix_valid);
  assign src_cmd   = pix_valid ? pix_cmd : reg_cmd; // never both valid

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      full <= 1'b0;
    end else if (load) begin
      full <= 1'b1;                                 // reload in the same cycle as take
    end else if (take) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) draw_cmd <= src_cmd;
  end

  assign draw_cmd_rdy = full;

endmodule

//--- src/geometry_xy_plotter.sv
`timescale 1ns/1ps

module geometry_xy_plotter #(
  parameter int FIFO_DEPTH  = 512,
  parameter int FIFO_MARGIN = 32
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   fifo_cmd_ready,
  input  logic [15:0]            fifo_cmd_in,
  input  logic                   draw_busy,
  output logic                   fifo_cmd_busy,
  output logic                   load_cmd,
  output logic                   draw_cmd_rdy,
  output plotter_pkg::draw_cmd_t draw_cmd
);
  import plotter_pkg::*;

  cmd_word_t fifo_q;                                // head of command FIFO
  logic      fifo_empty;
  logic      pop;
  logic      out_ready;                             // output slot can take a command
  logic      rect_busy;
  logic      start;
  logic      reg_valid;
  logic      pix_valid;
  draw_cmd_t reg_cmd;
  draw_cmd_t pix_cmd;
  rect_job_t rect_job;

  cmd_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .FIFO_MARGIN(FIFO_MARGIN)
  ) u_fifo (
    .clk        (clk),
    .reset      (reset),
    .wr         (fifo_cmd_ready),
    .din        (cmd_word_t'(fifo_cmd_in)),
    .pop        (pop),
    .q          (fifo_q),
    .empty      (fifo_empty),
    .almost_full(fifo_cmd_busy)
  );

  cmd_decoder u_dec (
    .clk(clk), .reset(reset), .head(fifo_q), .empty(fifo_empty), .out_ready(out_ready),
    .rect_busy(rect_busy), .pop(pop), .load_cmd(load_cmd), .reg_cmd(reg_cmd),
    .reg_valid(reg_valid), .rect_job(rect_job), .start(start)
  );

  rect_engine u_rect (
    .clk(clk), .reset(reset), .start(start), .job(rect_job), .out_ready(out_ready),
    .pix_cmd(pix_cmd), .pix_valid(pix_valid), .rect_busy(rect_busy)
  );

  draw_cmd_out u_out (
    .clk(clk), .reset(reset), .reg_cmd(reg_cmd), .pix_cmd(pix_cmd), .reg_valid(reg_valid),
    .pix_valid(pix_valid), .draw_busy(draw_busy), .out_ready(out_ready),
    .draw_cmd(draw_cmd), .draw_cmd_rdy(draw_cmd_rdy)
  );

endmodule

//--- testbench/tb_cases.svh
// one add_row per test with name, word count, command words in push order,
// expected count and draw commands in take order as aux_color_y_x
task automatic build_table();
  add_row("addr_rwdth", 15,
          {16'h8011, 16'hC022, 16'h9033, 16'hD044, 16'hA055, 16'hE066, 16'hB077, 16'hF088,
           16'h7CA5, 16'h7F3C, 16'h7912, 16'h7301, 16'h7102, 16'h7203, 16'h7004},
          7, {36'hE_A5_022_011, 36'hE_3C_088_077, 36'hF_12_044_033, 36'hC_01_066_055,
              36'hC_02_088_077, 36'hD_03_066_055, 36'hD_04_088_077});
  add_row("rst_mask_clip", 4, {16'h5BA7, 16'h5E00, 16'h5A3C, 16'h5C00},
          2, {36'hA_A7_A7A_07A, 36'hB_3C_3C3_0C3});   // clip ops give nothing
  add_row("rect_fill_rev", 13,                        // clip 100,100 then two rectangles
          {16'hB064, 16'hF064, 16'h5C00, 16'h8005, 16'hC004, 16'h9003, 16'hD003, 16'h0A55,
           16'h8007, 16'hC001, 16'h9007, 16'hD003, 16'h0A66},
          9, {36'h1_55_004_005, 36'h1_55_004_004, 36'h1_55_004_003, 36'h1_55_003_005,
              36'h1_55_003_004, 36'h1_55_003_003, 36'h1_66_001_007, 36'h1_66_002_007,
              36'h1_66_003_007});
  add_row("rect_outline", 11,                         // outline then silent shape codes
          {16'h800A, 16'hC014, 16'h900D, 16'hD017, 16'h0277, 16'h0011, 16'h0122, 16'h0333,
           16'h0F44, 16'h1E55, 16'h4000},
          12, {36'h1_77_014_00A, 36'h1_77_014_00B, 36'h1_77_014_00C, 36'h1_77_014_00D,
               36'h1_77_015_00A, 36'h1_77_015_00D, 36'h1_77_016_00A, 36'h1_77_016_00D,
               36'h1_77_017_00A, 36'h1_77_017_00B, 36'h1_77_017_00C, 36'h1_77_017_00D});
  add_row("rect_clip", 8,                             // clip 2,2 and corners -1,-1 to 3,3
          {16'hA002, 16'hE002, 16'h5D00, 16'h8FFF, 16'hCFFF, 16'h9003, 16'hD003, 16'h0A99},
          9, {36'h1_99_000_000, 36'h1_99_000_001, 36'h1_99_000_002, 36'h1_99_001_000,
              36'h1_99_001_001, 36'h1_99_001_002, 36'h1_99_002_000, 36'h1_99_002_001,
              36'h1_99_002_002});
endtask

//--- testbench/tb_geometry_xy_plotter.sv
`timescale 1ns/1ps

module tb_geometry_xy_plotter;
  import plotter_pkg::*;

  localparam int fifo_depth     = 64;
  localparam int fifo_margin    = 8;
  localparam int timeout_cycles = 2000;             // per wait loop
  localparam int idle_cycles    = 20;               // longer than any row of silent words

  logic        clk;
  logic        reset;
  logic        fifo_cmd_ready;
  logic [15:0] fifo_cmd_in;
  logic        draw_busy;
  logic        fifo_cmd_busy;
  logic        load_cmd;
  logic        draw_cmd_rdy;
  draw_cmd_t   draw_cmd;

  integer      seed = 32'haf1f6fa4;
  logic        hold_busy;                           // pins draw_busy high for back-pressure
  logic        busy_seen;                           // load_cmd dropped during the current test
  int          errors;
  int          tests_run;
  int          tests_failed;
  draw_cmd_t   got_q [$];                           // commands taken by the pixel writer

  // table storage filled by build_table
  string        row_name [$];
  int           row_nw [$];
  int           row_ne [$];
  logic [255:0] row_words [$];                      // up to 16 words with the first highest
  logic [575:0] row_exps [$];                       // up to 16 draw commands, first highest

  geometry_xy_plotter #(
    .FIFO_DEPTH (fifo_depth),
    .FIFO_MARGIN(fifo_margin)
  ) dut0 (
    .clk(clk), .reset(reset), .fifo_cmd_ready(fifo_cmd_ready), .fifo_cmd_in(fifo_cmd_in),
    .draw_busy(draw_busy), .fifo_cmd_busy(fifo_cmd_busy), .load_cmd(load_cmd),
    .draw_cmd_rdy(draw_cmd_rdy), .draw_cmd(draw_cmd)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;                         // 100 ns period
  end

  // ************************************************************
  // pixel writer model and monitor
  // ************************************************************
  always @(posedge clk) begin
    if (!reset) draw_busy <= hold_busy || ($random(seed) & 1);   // random stalls
  end

  always @(posedge clk) begin
    if (!reset && draw_cmd_rdy && !draw_busy) got_q.push_back(draw_cmd);   // taken this edge
  end

  always @(posedge clk) begin
    if (!reset && !load_cmd) busy_seen <= 1'b1;
  end

  task automatic add_row(input string name, input int nw, input logic [255:0] words,
                         input int ne, input logic [575:0] exps);
    row_name.push_back(name);
    row_nw.push_back(nw);
    row_words.push_back(words);
    row_ne.push_back(ne);
    row_exps.push_back(exps);
  endtask

  `include "tb_cases.svh"

  // collision-counter reset puts d then its high nibble in y, low then high nibble in x
  function automatic draw_cmd_t mask_reset_cmd(input logic [7:0] d);
    draw_cmd_t c;
    c.aux   = 4'd10;
    c.color = d;
    c.y     = {d, d[7:4]};
    c.x     = {4'h0, d[3:0], d[7:4]};
    return c;
  endfunction

  // ************************************************************
  // drive and wait helpers
  // ************************************************************
  task automatic push_word(input logic [15:0] word, input bit obey_busy);
    int waited;
    waited = 0;
    @(posedge clk);
    while (obey_busy && fifo_cmd_busy && waited < timeout_cycles) begin
      fifo_cmd_ready <= 1'b0;                       // hold off while almost full
      @(posedge clk);
      waited++;
    end
    if (waited >= timeout_cycles) begin
      $display("fifo_cmd_busy stayed high too long at %0t ns", $time);
      errors++;
    end
    fifo_cmd_in    <= word;
    fifo_cmd_ready <= 1'b1;
  endtask

  task automatic end_push();
    @(posedge clk);
    fifo_cmd_ready <= 1'b0;
  endtask

  task automatic wait_for_count(input string name, input int n);
    int t;
    t = 0;
    while (got_q.size() < n && t < timeout_cycles) begin
      @(negedge clk);
      t++;
    end
    if (got_q.size() < n) begin
      $display("%s: timed out waiting for draw commands, %0d of %0d seen", name,
               got_q.size(), n);
      errors++;
    end
  endtask

  task automatic wait_idle(input string name);
    int t;
    int quiet;
    t     = 0;
    quiet = 0;
    while (quiet < idle_cycles && t < timeout_cycles) begin
      @(negedge clk);
      t++;
      if (load_cmd && !draw_cmd_rdy) quiet++;
      else                           quiet = 0;
    end
    if (quiet < idle_cycles) begin
      $display("%s: unit never went idle", name);
      errors++;
    end
  endtask

  task automatic compare_cmd(input string name, input int idx, input draw_cmd_t got,
                             input draw_cmd_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s command %0d got %h expected %h", $time, name, idx,
               got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int ne, input int errs_before);
    if (got_q.size() > ne) begin
      $display("%s: %0d extra draw commands came out", name, got_q.size() - ne);
      errors++;
    end
    tests_run++;
    if (errors == errs_before) begin
      $display("test %-14s ok, %0d commands", name, got_q.size());
    end else begin
      tests_failed++;
      $display("test %-14s failed", name);
    end
  endtask

  // ************************************************************
  // tests
  // ************************************************************
  task automatic run_row(input int r);
    int           nw;
    int           ne;
    int           errs_before;
    bit           has_pix;
    logic [255:0] words;
    logic [575:0] exps;
    nw          = row_nw[r];
    ne          = row_ne[r];
    words       = row_words[r];
    exps        = row_exps[r];
    errs_before = errors;
    got_q.delete();
    busy_seen   = 1'b0;
    for (int i = 0; i < nw; i++) push_word(words[(nw-1-i)*16 +: 16], 1'b1);
    end_push();
    wait_for_count(row_name[r], ne);
    wait_idle(row_name[r]);
    for (int i = 0; i < ne && i < got_q.size(); i++)
      compare_cmd(row_name[r], i, got_q[i], exps[(ne-1-i)*36 +: 36]);
    has_pix = 1'b0;
    for (int i = 0; i < ne; i++)
      if (exps[(ne-1-i)*36+32 +: 4] == 4'd1) has_pix = 1'b1;   // write-pixel code
    if (busy_seen != has_pix) begin
      $display("%s: load_cmd busy phase %s", row_name[r],
               has_pix ? "missing for a rectangle" : "seen without a rectangle");
      errors++;
    end
    finish_test(row_name[r], ne, errs_before);
  endtask

  task automatic run_backpressure();
    int n;
    int t;
    int errs_before;
    n           = fifo_depth - fifo_margin + 1;     // one past the almost-full threshold
    errs_before = errors;
    got_q.delete();
    @(negedge clk);
    hold_busy = 1'b1;
    for (int i = 0; i < n; i++) push_word({8'h5B, 8'(i * 7 + 3)}, 1'b0);   // uses the margin
    end_push();
    t = 0;
    while (!fifo_cmd_busy && t < timeout_cycles) begin
      @(negedge clk);
      t++;
    end
    if (!fifo_cmd_busy) begin
      $display("backpressure: fifo_cmd_busy never rose");
      errors++;
    end
    if (!draw_cmd_rdy) begin
      $display("backpressure: output slot held no command while draw_busy was high");
      errors++;
    end else begin
      compare_cmd("backpressure", 0, draw_cmd, mask_reset_cmd(8'd3));   // first word waits
    end
    @(negedge clk);
    hold_busy = 1'b0;
    wait_for_count("backpressure", n);
    wait_idle("backpressure");
    for (int i = 0; i < n && i < got_q.size(); i++)
      compare_cmd("backpressure", i, got_q[i], mask_reset_cmd(8'(i * 7 + 3)));
    if (fifo_cmd_busy) begin
      $display("backpressure: fifo_cmd_busy still high after the FIFO drained");
      errors++;
    end
    finish_test("backpressure", n, errs_before);
  endtask

  initial begin
    int r;
    reset          = 1'b1;
    fifo_cmd_ready = 1'b0;
    fifo_cmd_in    = '0;
    draw_busy      = 1'b0;
    hold_busy      = 1'b0;
    busy_seen      = 1'b0;
    errors         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    build_table();
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    for (r = 0; r < row_name.size(); r++) run_row(r);
    run_backpressure();
    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+testbench
common/plotter_pkg.sv
src/cmd_fifo.sv
geometry/cmd_decoder.sv
geometry/rect_engine.sv
src/draw_cmd_out.sv
src/geometry_xy_plotter.sv
testbench/tb_geometry_xy_plotter.sv

//--- Bender.yml
package:
  name: geometry_xy_plotter

sources:
  - common/plotter_pkg.sv
  - src/cmd_fifo.sv
  - geometry/cmd_decoder.sv
  - geometry/rect_engine.sv
  - src/draw_cmd_out.sv
  - src/geometry_xy_plotter.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_geometry_xy_plotter.sv
